/* hdl/ldst_bank_port.sv */
// One access per cycle on a single-port array with no reset of its contents; channel 0 reads, 1 writes
`timescale 1ns/1ns
`default_nettype none

module ldst_bank_port (
	input	wire							clock,
	input	wire							rst_n,
	input	wire [ldst_pkg::NUM_CHAN-1:0]	beat_req,
	input	ldst_pkg::addr_t				beat_addr		[ldst_pkg::NUM_CHAN],
	input	ldst_pkg::issue_no_t			beat_issue_no	[ldst_pkg::NUM_CHAN],
	input	ldst_pkg::tag_t					beat_dst		[ldst_pkg::NUM_CHAN],
	input	ldst_pkg::len_t					beat_index		[ldst_pkg::NUM_CHAN],
	input	ldst_pkg::data_t				beat_fill		[ldst_pkg::NUM_CHAN],
	input	wire [ldst_pkg::NUM_CHAN-1:0]	beat_last,
	input	wire [ldst_pkg::NUM_CHAN-1:0]	beat_empty,
	input	ldst_pkg::issue_no_t			next_issue_no,
	output	logic [ldst_pkg::NUM_CHAN-1:0]	beat_grant,
	output	logic							wb_valid,
	output	ldst_pkg::tag_t					wb_dst,
	output	ldst_pkg::len_t					wb_index,
	output	ldst_pkg::data_t				wb_data,
	output	logic							done_valid,
	output	ldst_pkg::issue_no_t			done_issue_no,
	output	logic							done_store
);

	import ldst_pkg::*;

	data_t		mem	[1 << ADDR_W];		// Scratch memory

	addr_t		sel_addr;
	issue_no_t	sel_issue_no;
	tag_t		sel_dst;
	len_t		sel_index;
	data_t		sel_fill;
	logic		sel_last;
	logic		sel_empty;
	logic		wr_fire;
	logic		rd_fire;

	//////////////////////
	// Age arbitration
	//////////////////////
	// Age is measured back from the next issue number, so wrap is harmless
	always_comb begin
		issue_no_t	age;
		issue_no_t	best_age;

		beat_grant	= '0;
		best_age	= '0;
		for (int c = 0; c < NUM_CHAN; c++) begin
			age = next_issue_no - beat_issue_no[c];
			if (beat_req[c] && ((beat_grant == '0) || (age > best_age))) begin
				beat_grant		= '0;
				beat_grant[c]	= 1'b1;
				best_age		= age;
			end
		end
	end

	// Fields of the granted beat
	always_comb begin
		sel_addr		= '0;
		sel_issue_no	= '0;
		sel_dst			= '0;
		sel_index		= '0;
		sel_fill		= '0;
		sel_last		= 1'b0;
		sel_empty		= 1'b0;
		for (int c = 0; c < NUM_CHAN; c++) begin
			if (beat_grant[c]) begin
				sel_addr		= beat_addr[c];
				sel_issue_no	= beat_issue_no[c];
				sel_dst			= beat_dst[c];
				sel_index		= beat_index[c];
				sel_fill		= beat_fill[c];
				sel_last		= beat_last[c];
				sel_empty		= beat_empty[c];
			end
		end
	end

	assign wr_fire	= beat_grant[CHAN_ST] && !sel_empty;	// Memset element
	assign rd_fire	= beat_grant[CHAN_LD] && !sel_empty;

	//////////////////////
	// Memory access and results
	//////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_valid	<= 1'b0;
			done_valid	<= 1'b0;
		end else begin
			wb_valid	<= rd_fire;
			done_valid	<= (beat_grant != '0) && sel_last;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			mem[sel_addr]	<= sel_fill;
		end
		if (rd_fire) begin
			wb_data		<= mem[sel_addr];
			wb_dst		<= sel_dst;
			wb_index	<= sel_index;
		end
		if (sel_last) begin
			done_issue_no	<= sel_issue_no;
			done_store		<= beat_grant[CHAN_ST];
		end
	end

endmodule

`default_nettype wire

/* hdl/ldst_channel.sv */
// Strictly in-order; a dropped command never reaches here, and a count of 0 still takes one beat
`timescale 1ns/1ns
`default_nettype none

module ldst_channel #(
	parameter int DEPTH_BUFF = ldst_pkg::DEPTH_BUFF
) (
	input	wire					clock,
	input	wire					rst_n,
	input	wire					enq_valid,
	input	ldst_pkg::issue_no_t	enq_issue_no,
	input	ldst_pkg::tag_t			enq_dst,
	input	ldst_pkg::addr_t		enq_base,
	input	ldst_pkg::addr_t		enq_stride,
	input	ldst_pkg::len_t			enq_len,
	input	ldst_pkg::data_t		enq_fill,
	output	logic					chan_full,
	output	logic					beat_req,
	output	ldst_pkg::addr_t		beat_addr,
	output	ldst_pkg::issue_no_t	beat_issue_no,
	output	ldst_pkg::tag_t			beat_dst,
	output	ldst_pkg::len_t			beat_index,
	output	ldst_pkg::data_t		beat_fill,
	output	logic					beat_last,
	output	logic					beat_empty,
	input	wire					beat_grant
);

	import ldst_pkg::*;

	// Queue storage, one array per field
	issue_no_t	q_issue_no	[DEPTH_BUFF];
	tag_t		q_dst		[DEPTH_BUFF];
	addr_t		q_base		[DEPTH_BUFF];
	addr_t		q_stride	[DEPTH_BUFF];
	len_t		q_len		[DEPTH_BUFF];
	data_t		q_fill		[DEPTH_BUFF];

	logic [$clog2(DEPTH_BUFF)-1:0]		wr_ptr;
	logic [$clog2(DEPTH_BUFF)-1:0]		rd_ptr;
	logic [$clog2(DEPTH_BUFF)-1:0]		next_ptr;
	logic [$clog2(DEPTH_BUFF+1)-1:0]	q_count;
	logic								push;
	logic								pop;
	logic								chain;

	chan_state_t	state;
	addr_t			cur_addr;		// Running strided address
	len_t			cur_index;		// Element index of the head beat
	len_t			last_index;

	//////////////////////
	// Command queue
	//////////////////////
	assign push			= enq_valid && (q_count != DEPTH_BUFF);
	assign pop			= (state == S_FINISH) || chain;
	assign next_ptr		= (rd_ptr == DEPTH_BUFF - 1) ? '0 : rd_ptr + 1'b1;

	// The strobe in flight counts too, since it lands one cycle later
	assign chan_full	= (q_count == DEPTH_BUFF) ||
						  (enq_valid && (q_count == DEPTH_BUFF - 1));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			q_count	<= '0;
		end else begin
			if (push) begin
				wr_ptr	<= (wr_ptr == DEPTH_BUFF - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr	<= next_ptr;
			end
			case ({push, pop})
				2'b10:		q_count	<= q_count + 1'b1;
				2'b01:		q_count	<= q_count - 1'b1;
				default:	q_count	<= q_count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			q_issue_no[wr_ptr]	<= enq_issue_no;
			q_dst[wr_ptr]		<= enq_dst;
			q_base[wr_ptr]		<= enq_base;
			q_stride[wr_ptr]	<= enq_stride;
			q_len[wr_ptr]		<= enq_len;
			q_fill[wr_ptr]		<= enq_fill;
		end
	end

	//////////////////////
	// Address sequencer
	//////////////////////
	// Next queued command follows the last beat without a gap
	assign chain	= (state == S_RUN) && beat_grant && beat_last && (q_count > 1);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state	<= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (q_count != '0) begin
						state	<= S_RUN;
					end
				end
				S_RUN: begin
					if (beat_grant && beat_last && !chain) begin
						state	<= S_FINISH;
					end
				end
				S_FINISH:	state	<= S_IDLE;	// Head popped here
				default:	state	<= S_IDLE;
			endcase
		end
	end

	// Head command is loaded while idle or on a chained pop, then stepped on each grant
	always_ff @(posedge clock) begin
		if (state == S_IDLE) begin
			cur_addr	<= q_base[rd_ptr];
			cur_index	<= '0;
			last_index	<= q_len[rd_ptr] - 1'b1;
		end else if (chain) begin
			cur_addr	<= q_base[next_ptr];
			cur_index	<= '0;
			last_index	<= q_len[next_ptr] - 1'b1;
		end else if ((state == S_RUN) && beat_grant) begin
			cur_addr	<= cur_addr + q_stride[rd_ptr];	// Wraps at 1023
			cur_index	<= cur_index + 1'b1;
		end
	end

	//////////////////////
	// Head beat
	//////////////////////
	assign beat_req			= (state == S_RUN);
	assign beat_addr		= cur_addr;
	assign beat_index		= cur_index;
	assign beat_issue_no	= q_issue_no[rd_ptr];
	assign beat_dst			= q_dst[rd_ptr];
	assign beat_fill		= q_fill[rd_ptr];
	assign beat_empty		= (q_len[rd_ptr] == '0);		// No memory access
	assign beat_last		= beat_empty || (cur_index == last_index);

endmodule

`default_nettype wire

/* hdl/ldst_engine.sv */
// Idle load latency is 4+k cycles per element k; commands strobed while cmd_stall is high may be lost
`timescale 1ns/1ns
`default_nettype none

module ldst_engine (
	input	wire					clock,
	input	wire					rst_n,
	input	wire					cmd_valid,
	input	wire					cmd_store,
	input	ldst_pkg::tag_t			cmd_dst,
	input	ldst_pkg::addr_t		cmd_base,
	input	ldst_pkg::addr_t		cmd_stride,
	input	ldst_pkg::len_t			cmd_len,
	input	ldst_pkg::data_t		cmd_fill,
	output	logic					cmd_stall,
	output	logic					wb_valid,
	output	ldst_pkg::tag_t			wb_dst,
	output	ldst_pkg::len_t			wb_index,
	output	ldst_pkg::data_t		wb_data,
	output	logic					done_valid,
	output	ldst_pkg::issue_no_t	done_issue_no,
	output	logic					done_store
);

	import ldst_pkg::*;

	// Issue stage to channels
	logic [NUM_CHAN-1:0]	chan_full;
	logic [NUM_CHAN-1:0]	enq_valid;
	issue_no_t				enq_issue_no;
	tag_t					enq_dst;
	addr_t					enq_base;
	addr_t					enq_stride;
	len_t					enq_len;
	data_t					enq_fill;
	issue_no_t				next_issue_no;

	// Channels to bank port
	logic [NUM_CHAN-1:0]	beat_req;
	addr_t					beat_addr		[NUM_CHAN];
	issue_no_t				beat_issue_no	[NUM_CHAN];
	tag_t					beat_dst		[NUM_CHAN];
	len_t					beat_index		[NUM_CHAN];
	data_t					beat_fill		[NUM_CHAN];
	logic [NUM_CHAN-1:0]	beat_last;
	logic [NUM_CHAN-1:0]	beat_empty;
	logic [NUM_CHAN-1:0]	beat_grant;

	ldst_issue u_issue (
		.clock			(clock),
		.rst_n			(rst_n),
		.cmd_valid		(cmd_valid),
		.cmd_store		(cmd_store),
		.cmd_dst		(cmd_dst),
		.cmd_base		(cmd_base),
		.cmd_stride		(cmd_stride),
		.cmd_len		(cmd_len),
		.cmd_fill		(cmd_fill),
		.chan_full		(chan_full),
		.cmd_stall		(cmd_stall),
		.enq_valid		(enq_valid),
		.enq_issue_no	(enq_issue_no),
		.enq_dst		(enq_dst),
		.enq_base		(enq_base),
		.enq_stride		(enq_stride),
		.enq_len		(enq_len),
		.enq_fill		(enq_fill),
		.next_issue_no	(next_issue_no)
	);

	//////////////////////
	// Channel 0 loads, channel 1 stores
	//////////////////////
	for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
		ldst_channel #(
			.DEPTH_BUFF		(DEPTH_BUFF)
		) u_channel (
			.clock			(clock),
			.rst_n			(rst_n),
			.enq_valid		(enq_valid[c]),
			.enq_issue_no	(enq_issue_no),
			.enq_dst		(enq_dst),
			.enq_base		(enq_base),
			.enq_stride		(enq_stride),
			.enq_len		(enq_len),
			.enq_fill		(enq_fill),
			.chan_full		(chan_full[c]),
			.beat_req		(beat_req[c]),
			.beat_addr		(beat_addr[c]),
			.beat_issue_no	(beat_issue_no[c]),
			.beat_dst		(beat_dst[c]),
			.beat_index		(beat_index[c]),
			.beat_fill		(beat_fill[c]),
			.beat_last		(beat_last[c]),
			.beat_empty		(beat_empty[c]),
			.beat_grant		(beat_grant[c])
		);
	end

	ldst_bank_port u_bank_port (
		.clock			(clock),
		.rst_n			(rst_n),
		.beat_req		(beat_req),
		.beat_addr		(beat_addr),
		.beat_issue_no	(beat_issue_no),
		.beat_dst		(beat_dst),
		.beat_index		(beat_index),
		.beat_fill		(beat_fill),
		.beat_last		(beat_last),
		.beat_empty		(beat_empty),
		.next_issue_no	(next_issue_no),
		.beat_grant		(beat_grant),
		.wb_valid		(wb_valid),
		.wb_dst			(wb_dst),
		.wb_index		(wb_index),
		.wb_data		(wb_data),
		.done_valid		(done_valid),
		.done_issue_no	(done_issue_no),
		.done_store		(done_store)
	);

endmodule

`default_nettype wire

/* hdl/ldst_issue.sv */
// No back-pressure on cmd_valid; a command whose channel is full is dropped and gets no issue number
`timescale 1ns/1ns
`default_nettype none

module ldst_issue (
	input	wire							clock,
	input	wire							rst_n,
	input	wire							cmd_valid,		// Single-cycle strobe
	input	wire							cmd_store,		// 1 = store, 0 = load
	input	ldst_pkg::tag_t					cmd_dst,
	input	ldst_pkg::addr_t				cmd_base,
	input	ldst_pkg::addr_t				cmd_stride,
	input	ldst_pkg::len_t					cmd_len,
	input	ldst_pkg::data_t				cmd_fill,
	input	wire [ldst_pkg::NUM_CHAN-1:0]	chan_full,
	output	logic							cmd_stall,
	output	logic [ldst_pkg::NUM_CHAN-1:0]	enq_valid,
	output	ldst_pkg::issue_no_t			enq_issue_no,
	output	ldst_pkg::tag_t					enq_dst,
	output	ldst_pkg::addr_t				enq_base,
	output	ldst_pkg::addr_t				enq_stride,
	output	ldst_pkg::len_t					enq_len,
	output	ldst_pkg::data_t				enq_fill,
	output	ldst_pkg::issue_no_t			next_issue_no
);

	import ldst_pkg::*;

	logic [NUM_CHAN-1:0]	target;		// One-hot target channel
	logic					accept;
	issue_no_t				issue_cnt;

	//////////////////////
	// Decode
	//////////////////////
	always_comb begin
		target = '0;
		target[cmd_store ? CHAN_ST : CHAN_LD] = 1'b1;
	end

	assign accept			= cmd_valid && ((target & chan_full) == '0);
	assign cmd_stall		= |chan_full;				// Warn before a drop
	assign next_issue_no	= issue_cnt;

	//////////////////////
	// Issue counter and strobe
	//////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			enq_valid	<= '0;
			issue_cnt	<= '0;
		end else begin
			enq_valid	<= accept ? target : '0;
			if (accept) begin
				issue_cnt	<= issue_cnt + 1'b1;	// Wraps modulo 64
			end
		end
	end

	// Command fields, held until the next accepted command
	always_ff @(posedge clock) begin
		if (accept) begin
			enq_issue_no	<= issue_cnt;
			enq_dst			<= cmd_dst;
			enq_base		<= cmd_base;
			enq_stride		<= cmd_stride;
			enq_len			<= cmd_len;
			enq_fill		<= cmd_fill;
		end
	end

endmodule

`default_nettype wire

/* hdl/ldst_pkg.sv */
// Single scratch memory of 1024 words; addresses, issue numbers and counts all wrap silently
`default_nettype none

package ldst_pkg;

	//////////////////////
	// Widths
	//////////////////////
	localparam int DATA_W		= 32;		// One data element
	localparam int ADDR_W		= 10;		// 1024-word scratch memory
	localparam int LEN_W		= 10;		// Element count, 0 allowed
	localparam int ISSUE_W		= 6;		// Issue number, modulo 64
	localparam int TAG_W		= 5;		// Destination tag

	//////////////////////
	// Channels
	//////////////////////
	localparam int NUM_CHAN		= 2;
	localparam int CHAN_LD		= 0;		// Load channel
	localparam int CHAN_ST		= 1;		// Store channel
	localparam int DEPTH_BUFF	= 4;		// Command queue depth

	//////////////////////
	// Types
	//////////////////////
	typedef logic [DATA_W-1:0]	data_t;
	typedef logic [ADDR_W-1:0]	addr_t;
	typedef logic [LEN_W-1:0]	len_t;
	typedef logic [ISSUE_W-1:0]	issue_no_t;
	typedef logic [TAG_W-1:0]	tag_t;

	// Address sequencer of one channel
	typedef enum logic [1:0] {
		S_IDLE,							// Waiting for a queued command
		S_RUN,							// Presenting beats
		S_FINISH						// Popping the finished command
	} chan_state_t;

endpackage

`default_nettype wire

/* ldst_engine.f */
hdl/ldst_pkg.sv
hdl/ldst_issue.sv
hdl/ldst_channel.sv
hdl/ldst_bank_port.sv
hdl/ldst_engine.sv
verif/tb_ldst_engine.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the load/store engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ldst_engine \
	-f ldst_engine.f -o sim_ldst_engine &&
	./obj_dir/sim_ldst_engine | tee sim.log
grep -q "^TEST PASS$" sim.log && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

/* verif/tb_ldst_engine.sv */
// Directed tests; loads only cover addresses that a store wrote earlier, since memory has no reset
`timescale 1ns/1ns
`default_nettype none

module tb_ldst_engine;

	import ldst_pkg::*;

	logic clock;
	logic rst_n;
	logic cmd_valid;
	logic cmd_store;
	tag_t cmd_dst;
	addr_t cmd_base;
	addr_t cmd_stride;
	len_t cmd_len;
	data_t cmd_fill;
	logic cmd_stall;
	logic wb_valid;
	tag_t wb_dst;
	len_t wb_index;
	data_t wb_data;
	logic done_valid;
	issue_no_t done_issue_no;
	logic done_store;

	data_t ref_mem [1 << ADDR_W];	// Reference memory, updated at issue
	tag_t exp_wb_dst [$];
	len_t exp_wb_index [$];
	data_t exp_wb_data [$];
	issue_no_t exp_done_no [$];
	logic exp_done_st [$];
	issue_no_t issue_cnt;
	logic [31:0] lcg_state;
	string cur_test;
	int errors;
	int checks;
	int cycle_cnt;
	int cycle_limit;

	ldst_engine UUT (
		.clock(clock), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_store(cmd_store),
		.cmd_dst(cmd_dst), .cmd_base(cmd_base), .cmd_stride(cmd_stride), .cmd_len(cmd_len),
		.cmd_fill(cmd_fill), .cmd_stall(cmd_stall), .wb_valid(wb_valid), .wb_dst(wb_dst),
		.wb_index(wb_index), .wb_data(wb_data), .done_valid(done_valid),
		.done_issue_no(done_issue_no), .done_store(done_store)
	);

	always #20 clock = ~clock;	// 40 ns period

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_cnt);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	////////////////////
	// Stimulus
	////////////////////
	// Strobe one command; the model follows only if it is accepted
	task automatic issue_cmd(input logic store, input tag_t dst, input addr_t base,
			input addr_t stride, input len_t len, input data_t fill, output logic accepted);
		addr_t a;
		@(posedge clock);
		#5;
		cmd_valid = 1'b1;
		cmd_store = store;
		cmd_dst = dst;
		cmd_base = base;
		cmd_stride = stride;
		cmd_len = len;
		cmd_fill = fill;
		accepted = !cmd_stall;	// Full channel drops it
		cycle_limit += int'(len) + 6;
		if (accepted) begin
			a = base;
			for (int k = 0; k < int'(len); k++) begin
				if (store) begin
					ref_mem[a] = fill;
				end else begin
					exp_wb_dst.push_back(dst);
					exp_wb_index.push_back(len_t'(k));
					exp_wb_data.push_back(ref_mem[a]);
				end
				a = a + stride;	// Wraps at 1023
			end
			exp_done_no.push_back(issue_cnt);
			exp_done_st.push_back(store);
			issue_cnt = issue_cnt + 1'b1;
		end
	endtask

	task automatic send_cmd(input logic store, input tag_t dst, input addr_t base,
			input addr_t stride, input len_t len, input data_t fill);
		logic acc;
		issue_cmd(store, dst, base, stride, len, fill, acc);
		if (!acc) begin
			errors++;
			$display("%s: command at base %0d was dropped with no full queue", cur_test, base);
		end
	endtask

	task automatic release_cmd();
		@(posedge clock);
		#5;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_done_no.size() != 0 || exp_wb_data.size() != 0) begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
	endtask

	////////////////////
	// Response checks
	////////////////////
	always @(negedge clock) begin
		if (rst_n && wb_valid) begin
			checks++;
			if (exp_wb_data.size() == 0) begin
				errors++;
				$display("%s: write-back of index %0d with none expected", cur_test, wb_index);
			end else if (wb_dst !== exp_wb_dst[0] || wb_index !== exp_wb_index[0]
					|| wb_data !== exp_wb_data[0]) begin
				errors++;
				$display("[ERROR] %s: expected dst %0d index %0d data %h, actual %0d %0d %h",
					cur_test, exp_wb_dst[0], exp_wb_index[0], exp_wb_data[0],
					wb_dst, wb_index, wb_data);
			end
			if (exp_wb_data.size() != 0) begin
				void'(exp_wb_dst.pop_front());
				void'(exp_wb_index.pop_front());
				void'(exp_wb_data.pop_front());
			end
		end
		if (rst_n && done_valid) begin
			checks++;
			if (exp_done_no.size() == 0) begin
				errors++;
				$display("%s: done for issue %0d with none expected", cur_test, done_issue_no);
			end else begin
				if (done_issue_no !== exp_done_no[0] || done_store !== exp_done_st[0]) begin
					errors++;
					$display("[ERROR] %s: expected issue %0d store %0d, actual %0d %0d",
						cur_test, exp_done_no[0], exp_done_st[0], done_issue_no, done_store);
				end
				void'(exp_done_no.pop_front());
				void'(exp_done_st.pop_front());
			end
		end
	end

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			errors++;
			$display("Timeout: engine still busy after %0d cycles", cycle_cnt);
			finish_run();
		end
	end

	////////////////////
	// Tests
	////////////////////
	task automatic test_fill_readback();
		addr_t base;
		len_t len;
		data_t fill;
		cur_test = "fill_readback";
		base = addr_t'(256 + next_random() % 128);
		len = len_t'(8 + next_random() % 8);
		fill = next_random();
		send_cmd(1'b1, '0, base, 10'd1, len, fill);
		release_cmd();
		wait_idle();
		send_cmd(1'b0, tag_t'(next_random()), base, 10'd1, len, '0);
		release_cmd();
		wait_idle();
	endtask

	task automatic test_strided_wrap();
		cur_test = "strided_wrap";
		send_cmd(1'b1, '0, 10'd1000, 10'd1, 10'd48, next_random());	// Old values
		release_cmd();
		wait_idle();
		send_cmd(1'b1, '0, 10'd1005, 10'd3, 10'd12, next_random());	// Crosses 1023
		send_cmd(1'b0, tag_t'(next_random()), 10'd1000, 10'd1, 10'd48, '0);
		release_cmd();
		wait_idle();
	endtask

	task automatic test_store_load_order();
		cur_test = "store_load_order";
		send_cmd(1'b1, '0, 10'd600, 10'd1, 10'd16, next_random());
		send_cmd(1'b0, tag_t'(next_random()), 10'd604, 10'd1, 10'd8, '0);	// Next cycle
		release_cmd();
		wait_idle();
	endtask

	task automatic test_completion();
		cur_test = "completion";
		send_cmd(1'b1, '0, 10'd700, 10'd2, 10'd5, next_random());
		send_cmd(1'b0, 5'd3, 10'd700, 10'd1, 10'd0, '0);	// No beats
		send_cmd(1'b1, '0, 10'd700, 10'd1, 10'd0, next_random());
		send_cmd(1'b0, 5'd4, 10'd700, 10'd2, 10'd5, '0);
		release_cmd();
		wait_idle();
		// Bursts of empty commands until the issue number wraps past 63
		for (int r = 0; r < 15; r++) begin
			send_cmd(1'b1, '0, 10'd0, 10'd1, 10'd0, next_random());
			send_cmd(1'b0, 5'd5, 10'd0, 10'd1, 10'd0, '0);
			send_cmd(1'b0, 5'd6, 10'd0, 10'd1, 10'd0, '0);
			send_cmd(1'b1, '0, 10'd0, 10'd1, 10'd0, next_random());
			release_cmd();
			wait_idle();
		end
	endtask

	task automatic test_queue_full();
		logic acc;
		int k;
		cur_test = "queue_full";
		send_cmd(1'b1, '0, 10'd256, 10'd1, 10'd48, next_random());	// Region of dropped store
		release_cmd();
		wait_idle();
		k = 0;
		acc = 1'b1;
		while (acc && k <= DEPTH_BUFF) begin
			issue_cmd(1'b1, '0, addr_t'(k * 64), 10'd1, len_t'(32 + next_random() % 16),
				next_random(), acc);
			if (acc) begin
				k++;
			end
		end
		release_cmd();
		if (k != DEPTH_BUFF) begin
			errors++;
			$display("[ERROR] %s: expected %0d accepted stores, actual %0d", cur_test,
				DEPTH_BUFF, k);
		end
		wait_idle();
		send_cmd(1'b0, 5'd9, 10'd256, 10'd1, 10'd48, '0);
		release_cmd();
		wait_idle();
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_store = 1'b0;
		cmd_dst = '0;
		cmd_base = '0;
		cmd_stride = '0;
		cmd_len = '0;
		cmd_fill = '0;
		issue_cnt = '0;
		lcg_state = 32'h1f9de490;
		errors = 0;
		checks = 0;
		cycle_cnt = 0;
		cycle_limit = 200;
		cur_test = "reset";
		repeat (3) @(posedge clock);
		#5;
		rst_n = 1'b1;
		checks++;
		if (cmd_stall !== 1'b0 || wb_valid !== 1'b0 || done_valid !== 1'b0) begin
			errors++;
			$display("[ERROR] %s: expected stall wb done 000, actual %b%b%b", cur_test,
				cmd_stall, wb_valid, done_valid);
		end
		test_fill_readback();
		test_strided_wrap();
		test_store_load_order();
		test_completion();
		test_queue_full();
		finish_run();
	end

endmodule

`default_nettype wire
